// ==== Makefile ====
# Verilator build and run for the scratchpad DMA bridge

VERILATOR ?= verilator
TOP       ?= tb_ddr_dma
RTL_TOP   ?= ddr_dma_top
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
src/ddr_dma_pkg.sv
src/spad_ram.sv
src/dma_regs.sv
src/dma_engine.sv
src/mig_port_model.sv
src/ddr_dma_top.sv
sim/ddr_dma_props.sv
sim/tb_ddr_dma.sv

// ==== sim/ddr_dma_props.sv ====
`timescale 1ns/100ps

module ddr_dma_props (
    input logic clk,
    input logic rst,
    input logic start_wr_i,
    input logic start_rd_i,
    input logic idle_o,
    input logic cmd_en_o,
    input logic cmd_full_i,
    input logic wr_en_o,
    input logic wr_full_i,
    input logic rd_en_o,
    input logic rd_empty_i
);

    logic [3:0]  cmd_cnt_q;      // Commands since the last accepted start
    int unsigned fail_cnt = 0;   // Failed assertions so far

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_cnt_q <= '0;
        end else if (idle_o && (start_wr_i || start_rd_i)) begin
            cmd_cnt_q <= '0;
        end else if (cmd_en_o) begin
            cmd_cnt_q <= cmd_cnt_q + 1'b1;
        end
    end

    cmd_vs_full: assert property (@(posedge clk) disable iff (rst) !(cmd_en_o && cmd_full_i))
        else begin
            $error("cmd_en while cmd_full");
            fail_cnt++;
        end

    wr_vs_full: assert property (@(posedge clk) disable iff (rst) !(wr_en_o && wr_full_i))
        else begin
            $error("wr_en while wr_full");
            fail_cnt++;
        end

    rd_vs_empty: assert property (@(posedge clk) disable iff (rst) rd_en_o |-> !rd_empty_i)
        else begin
            $error("rd_en while rd_empty");
            fail_cnt++;
        end

    one_cmd: assert property (@(posedge clk) disable iff (rst) $rose(idle_o) |-> cmd_cnt_q == 4'd1)
        else begin
            $error("cmd_en count per transfer is not one");
            fail_cnt++;
        end

    quiet_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!wr_en_o && !rd_en_o && !cmd_en_o))
        else begin
            $error("FIFO or command enable high in reset");
            fail_cnt++;
        end

endmodule

bind dma_engine ddr_dma_props ddr_dma_props_inst (
    .clk(clk), .rst(rst),
    .start_wr_i(start_wr_i), .start_rd_i(start_rd_i), .idle_o(idle_o),
    .cmd_en_o(cmd_en_o), .cmd_full_i(cmd_full_i),
    .wr_en_o(wr_en_o), .wr_full_i(wr_full_i),
    .rd_en_o(rd_en_o), .rd_empty_i(rd_empty_i)
);

// ==== sim/tb_ddr_dma.sv ====
`timescale 1ns/100ps

module tb_ddr_dma;

    localparam int MEM_WORDS  = 4096;
    localparam int RD_LATENCY = 4;
    localparam int TRANSFERS  = 40;
    localparam int BUS_OPS    = 8000;   // Upper bound on bus accesses
    localparam real LIMIT_NS  = (TRANSFERS * (64 + RD_LATENCY + 20) + BUS_OPS * 3) * 40.0;

    logic                   clk;
    logic                   rst;
    ddr_dma_pkg::bus_addr_t addr;
    ddr_dma_pkg::word_t     wdata;
    logic                   we;
    ddr_dma_pkg::word_t     rdata;

    ddr_dma_pkg::word_t spad_ref [1024];
    ddr_dma_pkg::word_t dram_ref [MEM_WORDS];

    ddr_dma_top #(.MEM_WORDS(MEM_WORDS), .RD_LATENCY(RD_LATENCY)) ddr_dma_top_inst (
        .clk(clk), .rst(rst), .addr_i(addr), .data_i(wdata), .we_i(we), .data_o(rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("Run did not finish within the time limit");
        $display("TB FAILED");
        $fatal(1);
    end

    // Engine protocol properties
    initial begin
        wait (ddr_dma_top_inst.dma_engine_inst.ddr_dma_props_inst.fail_cnt != 0);
        $display("Engine protocol assertion failed");
        $display("TB FAILED");
        $fatal(1);
    end

    task automatic bus_write(input ddr_dma_pkg::bus_addr_t a, input ddr_dma_pkg::word_t d);
        @(posedge clk);
        #2;
        addr  = a;
        wdata = d;
        we    = 1'b1;
        @(posedge clk);
        #2;
        we = 1'b0;
    endtask

    task automatic bus_read(input ddr_dma_pkg::bus_addr_t a, output ddr_dma_pkg::word_t d);
        @(posedge clk);
        #2;
        addr = a;
        we   = 1'b0;
        @(posedge clk);
        #2;
        d = rdata;   // Registered, one cycle after the address
    endtask

    task automatic check_read(input ddr_dma_pkg::bus_addr_t a, input ddr_dma_pkg::word_t exp);
        ddr_dma_pkg::word_t got;
        bus_read(a, got);
        assert (got === exp) else begin
            $display("[ERROR] data_o expected 0x%08h got 0x%08h at addr 0x%04h", exp, got, a);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_complete();
        ddr_dma_pkg::word_t v;
        do begin
            bus_read(ddr_dma_pkg::REG_CTRL, v);
        end while (v[0] !== 1'b1);
    endtask

    task automatic check_spad(input int start, input int count);
        int idx;
        for (int i = 0; i < count; i++) begin
            idx = (start + i) % 1024;
            check_read(16'h1000 | 16'(idx), spad_ref[idx]);
        end
    endtask

    task automatic apply_ref(input bit to_dram, input logic [31:0] dram_byte,
                             input int spad, input int len);
        int d;
        int s;
        for (int i = 0; i <= len; i++) begin
            d = (int'(dram_byte[26:2]) + i) % MEM_WORDS;
            s = (spad + i) % 1024;
            if (to_dram) begin
                dram_ref[d] = spad_ref[s];
            end else begin
                spad_ref[s] = dram_ref[d];
            end
        end
    endtask

    task automatic setup_regs(input logic [31:0] dram_byte, input int spad, input int len);
        bus_write(ddr_dma_pkg::REG_DRAM_ADDR, dram_byte);
        bus_write(ddr_dma_pkg::REG_SPAD_ADDR, 32'(spad));
        bus_write(ddr_dma_pkg::REG_BURST_LEN, 32'(len));
    endtask

    task automatic run_transfer(input bit to_dram, input logic [31:0] dram_byte,
                                input int spad, input int len);
        setup_regs(dram_byte, spad, len);
        bus_write(ddr_dma_pkg::REG_CTRL, {31'b0, to_dram});
        check_read(ddr_dma_pkg::REG_CTRL, 32'h0);   // Busy right after start
        wait_complete();
        apply_ref(to_dram, dram_byte, spad, len);
        check_read(ddr_dma_pkg::REG_DRAM_ADDR, dram_byte & 32'h07fffffc);
        check_read(ddr_dma_pkg::REG_SPAD_ADDR, 32'(spad) & 32'h3ff);
        check_read(ddr_dma_pkg::REG_BURST_LEN, 32'(len) & 32'h3f);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] db;
        int src;
        int dst;
        int len;
        int idx;
        void'($urandom(53953));
        rst   = 1'b1;
        addr  = '0;
        wdata = '0;
        we    = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        check_read(ddr_dma_pkg::REG_CTRL, 32'h1);
        r = $urandom;
        bus_write(ddr_dma_pkg::REG_DRAM_ADDR, r);
        check_read(ddr_dma_pkg::REG_DRAM_ADDR, r & 32'h07fffffc);
        r = $urandom;
        bus_write(ddr_dma_pkg::REG_SPAD_ADDR, r);
        check_read(ddr_dma_pkg::REG_SPAD_ADDR, r & 32'h3ff);
        r = $urandom;
        bus_write(ddr_dma_pkg::REG_BURST_LEN, r);
        check_read(ddr_dma_pkg::REG_BURST_LEN, r & 32'h3f);
        check_read(16'hc104, 32'h0);
        check_read(16'h2000, 32'h0);

        // Pattern over the full index
        for (int i = 0; i < 1024; i++) begin
            spad_ref[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0003);
            bus_write(16'h1000 | 16'(i), spad_ref[i]);
        end
        for (int i = 0; i < 32; i++) begin
            idx = $urandom % 1024;
            r = $urandom;
            spad_ref[idx] = r;
            bus_write(16'h1000 | 16'(($urandom % 4) << 10) | 16'(idx), r);
            check_read(16'h1000 | 16'(($urandom % 4) << 10) | 16'(idx), r);
        end

        for (int t = 0; t < 5; t++) begin
            src = $urandom % 1024;
            dst = (src + 512) % 1024;
            len = 1 + $urandom % 62;
            db  = $urandom & 32'h07fffffc;
            for (int i = 0; i <= len; i++) begin
                idx = (src + i) % 1024;
                spad_ref[idx] = $urandom;
                bus_write(16'h1000 | 16'(idx), spad_ref[idx]);
            end
            run_transfer(1'b1, db, src, len);
            run_transfer(1'b0, db, dst, len);
            check_spad(dst + 1023, len + 3);
        end

        run_transfer(1'b1, 32'h0000_0400, 200, 0);
        run_transfer(1'b0, 32'h0000_0400, 700, 0);
        check_spad(699, 3);
        run_transfer(1'b1, 32'h0000_2000, 1020, 63);
        run_transfer(1'b0, 32'h0000_2000, 300, 63);
        check_spad(299, 66);
        run_transfer(1'b0, 32'h0000_2000, 1010, 63);
        check_spad(1009, 66);

        // Second start lands while the first burst is still filling
        setup_regs(32'h0000_3000, 400, 63);
        bus_write(ddr_dma_pkg::REG_CTRL, 32'h1);
        bus_write(ddr_dma_pkg::REG_SPAD_ADDR, 32'd900);
        bus_write(ddr_dma_pkg::REG_CTRL, 32'h0);
        wait_complete();
        apply_ref(1'b1, 32'h0000_3000, 400, 63);
        check_spad(900, 64);
        run_transfer(1'b0, 32'h0000_3000, 500, 63);
        check_spad(499, 66);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== src/ddr_dma_pkg.sv ====
package ddr_dma_pkg;

    typedef logic [31:0] word_t;
    typedef logic [9:0]  spad_addr_t;     // Scratchpad word index
    typedef logic [24:0] dram_addr_t;     // DRAM word address
    typedef logic [5:0]  burst_len_t;     // Words minus one
    typedef logic [15:0] bus_addr_t;
    typedef logic [2:0]  mig_instr_t;

    typedef enum logic [2:0] {
        IDLE,
        FILL_WR,
        EMIT_WR,
        EMIT_RD,
        DRAIN_RD
    } dma_state_t;

    localparam mig_instr_t CMD_WR = 3'b010;
    localparam mig_instr_t CMD_RD = 3'b011;

    localparam logic [3:0] SPAD_REGION = 4'h1;   // Top nibble of bus address

    localparam bus_addr_t REG_DRAM_ADDR = 16'hc100;
    localparam bus_addr_t REG_SPAD_ADDR = 16'hc101;
    localparam bus_addr_t REG_BURST_LEN = 16'hc102;
    localparam bus_addr_t REG_CTRL      = 16'hc103;

endpackage

// ==== src/ddr_dma_top.sv ====
`timescale 1ns/100ps

module ddr_dma_top #(
    parameter int MEM_WORDS  = 4096,
    parameter int RD_LATENCY = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  ddr_dma_pkg::bus_addr_t addr_i,
    input  ddr_dma_pkg::word_t     data_i,
    input  logic                   we_i,
    output ddr_dma_pkg::word_t     data_o
);

    ddr_dma_pkg::spad_addr_t bus_addr;
    logic                    bus_we;
    ddr_dma_pkg::word_t      bus_wdata;
    ddr_dma_pkg::word_t      bus_rdata;
    logic                    start_wr;
    logic                    start_rd;
    ddr_dma_pkg::dram_addr_t dram_addr;
    ddr_dma_pkg::spad_addr_t spad_addr;
    ddr_dma_pkg::burst_len_t burst_len;
    logic                    idle;
    ddr_dma_pkg::spad_addr_t dma_addr;
    logic                    dma_we;
    ddr_dma_pkg::word_t      dma_wdata;
    ddr_dma_pkg::word_t      dma_rdata;
    logic                    cmd_en;
    ddr_dma_pkg::mig_instr_t cmd_instr;
    ddr_dma_pkg::burst_len_t cmd_bl;
    logic [29:0]             cmd_byte_addr;
    logic                    cmd_full;
    logic                    wr_en;
    ddr_dma_pkg::word_t      wr_data;
    logic                    wr_full;
    logic                    rd_en;
    ddr_dma_pkg::word_t      rd_data;
    logic                    rd_empty;

    dma_regs dma_regs_inst (
        .clk(clk), .rst(rst),
        .addr_i(addr_i), .data_i(data_i), .we_i(we_i), .data_o(data_o),
        .spad_addr_o(bus_addr), .spad_we_o(bus_we),
        .spad_wdata_o(bus_wdata), .spad_rdata_i(bus_rdata),
        .start_wr_o(start_wr), .start_rd_o(start_rd),
        .dram_addr_o(dram_addr), .dma_spad_addr_o(spad_addr),
        .burst_len_o(burst_len), .idle_i(idle)
    );

    spad_ram spad_ram_inst (
        .clk(clk),
        .a_addr_i(bus_addr), .a_we_i(bus_we), .a_wdata_i(bus_wdata), .a_rdata_o(bus_rdata),
        .b_addr_i(dma_addr), .b_we_i(dma_we), .b_wdata_i(dma_wdata), .b_rdata_o(dma_rdata)
    );

    dma_engine dma_engine_inst (
        .clk(clk), .rst(rst),
        .start_wr_i(start_wr), .start_rd_i(start_rd),
        .dram_addr_i(dram_addr), .spad_addr_i(spad_addr), .burst_len_i(burst_len),
        .idle_o(idle),
        .spad_addr_o(dma_addr), .spad_we_o(dma_we),
        .spad_wdata_o(dma_wdata), .spad_rdata_i(dma_rdata),
        .cmd_en_o(cmd_en), .cmd_instr_o(cmd_instr), .cmd_bl_o(cmd_bl),
        .cmd_byte_addr_o(cmd_byte_addr), .cmd_full_i(cmd_full),
        .wr_en_o(wr_en), .wr_data_o(wr_data), .wr_full_i(wr_full),
        .rd_en_o(rd_en), .rd_data_i(rd_data), .rd_empty_i(rd_empty)
    );

    mig_port_model #(
        .MEM_WORDS(MEM_WORDS),
        .RD_LATENCY(RD_LATENCY)
    ) mig_port_model_inst (
        .clk(clk), .rst(rst),
        .cmd_en_i(cmd_en), .cmd_instr_i(cmd_instr), .cmd_bl_i(cmd_bl),
        .cmd_byte_addr_i(cmd_byte_addr), .cmd_full_o(cmd_full),
        .wr_en_i(wr_en), .wr_data_i(wr_data), .wr_full_o(wr_full),
        .rd_en_i(rd_en), .rd_data_o(rd_data), .rd_empty_o(rd_empty)
    );

endmodule

// ==== src/dma_engine.sv ====
`timescale 1ns/100ps

module dma_engine (
    input  logic                    clk,
    input  logic                    rst,
    // Setup from registers
    input  logic                    start_wr_i,
    input  logic                    start_rd_i,
    input  ddr_dma_pkg::dram_addr_t dram_addr_i,
    input  ddr_dma_pkg::spad_addr_t spad_addr_i,
    input  ddr_dma_pkg::burst_len_t burst_len_i,
    output logic                    idle_o,
    // Scratchpad DMA port
    output ddr_dma_pkg::spad_addr_t spad_addr_o,
    output logic                    spad_we_o,
    output ddr_dma_pkg::word_t      spad_wdata_o,
    input  ddr_dma_pkg::word_t      spad_rdata_i,
    // Controller command port
    output logic                    cmd_en_o,
    output ddr_dma_pkg::mig_instr_t cmd_instr_o,
    output ddr_dma_pkg::burst_len_t cmd_bl_o,
    output logic [29:0]             cmd_byte_addr_o,
    input  logic                    cmd_full_i,
    // Write FIFO
    output logic                    wr_en_o,
    output ddr_dma_pkg::word_t      wr_data_o,
    input  logic                    wr_full_i,
    // Read FIFO
    output logic                    rd_en_o,
    input  ddr_dma_pkg::word_t      rd_data_i,
    input  logic                    rd_empty_i
);

    ddr_dma_pkg::dma_state_t state_q;
    ddr_dma_pkg::dram_addr_t dram_q;
    ddr_dma_pkg::burst_len_t len_q;
    ddr_dma_pkg::burst_len_t cnt_q;
    ddr_dma_pkg::spad_addr_t spad_ptr_q;
    logic                    fill_valid_q;
    logic                    issue_done_q;
    logic                    accept;
    logic                    advance;
    logic                    push;
    logic                    pop;
    logic                    filling;

    assign idle_o  = (state_q == ddr_dma_pkg::IDLE);
    assign accept  = idle_o && (start_wr_i || start_rd_i);   // Busy starts are dropped
    assign filling = (state_q == ddr_dma_pkg::FILL_WR);

    // One scratchpad read in flight toward the write FIFO
    assign push    = filling && fill_valid_q && !wr_full_i;
    assign advance = filling && (!fill_valid_q || !wr_full_i);
    assign pop     = (state_q == ddr_dma_pkg::DRAIN_RD) && !rd_empty_i;

    assign wr_en_o   = push;
    assign wr_data_o = spad_rdata_i;
    assign rd_en_o   = pop;

    // On a stall re-read the pending word so its data holds
    assign spad_addr_o  = (filling && !advance) ? spad_ptr_q - 1'b1 : spad_ptr_q;
    assign spad_we_o    = pop;
    assign spad_wdata_o = rd_data_i;

    assign cmd_en_o = ((state_q == ddr_dma_pkg::EMIT_WR) || (state_q == ddr_dma_pkg::EMIT_RD))
                      && !cmd_full_i;
    assign cmd_instr_o     = (state_q == ddr_dma_pkg::EMIT_RD) ? ddr_dma_pkg::CMD_RD
                                                               : ddr_dma_pkg::CMD_WR;
    assign cmd_bl_o        = len_q;
    assign cmd_byte_addr_o = {3'b000, dram_q, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= ddr_dma_pkg::IDLE;
            fill_valid_q <= 1'b0;
            issue_done_q <= 1'b0;
        end else begin
            case (state_q)
                ddr_dma_pkg::IDLE: begin
                    fill_valid_q <= 1'b0;
                    issue_done_q <= 1'b0;
                    if (start_wr_i) begin
                        state_q <= ddr_dma_pkg::FILL_WR;
                    end else if (start_rd_i) begin
                        state_q <= ddr_dma_pkg::EMIT_RD;
                    end
                end
                ddr_dma_pkg::FILL_WR: begin
                    if (advance) begin
                        fill_valid_q <= !issue_done_q;
                        if (!issue_done_q && cnt_q == '0) begin
                            issue_done_q <= 1'b1;
                        end
                    end
                    if (push && issue_done_q) begin
                        state_q <= ddr_dma_pkg::EMIT_WR;   // Last word pushed
                    end
                end
                ddr_dma_pkg::EMIT_WR: begin
                    if (!cmd_full_i) begin
                        state_q <= ddr_dma_pkg::IDLE;
                    end
                end
                ddr_dma_pkg::EMIT_RD: begin
                    if (!cmd_full_i) begin
                        state_q <= ddr_dma_pkg::DRAIN_RD;
                    end
                end
                ddr_dma_pkg::DRAIN_RD: begin
                    if (pop && cnt_q == '0) begin
                        state_q <= ddr_dma_pkg::IDLE;
                    end
                end
                default: state_q <= ddr_dma_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dram_q     <= dram_addr_i;
            len_q      <= burst_len_i;
            cnt_q      <= burst_len_i;
            spad_ptr_q <= spad_addr_i;
        end else if ((advance && !issue_done_q) || pop) begin
            spad_ptr_q <= spad_ptr_q + 1'b1;   // Wraps at 1024
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

// ==== src/dma_regs.sv ====
`timescale 1ns/100ps

module dma_regs (
    input  logic                    clk,
    input  logic                    rst,
    // Processor bus
    input  ddr_dma_pkg::bus_addr_t  addr_i,
    input  ddr_dma_pkg::word_t      data_i,
    input  logic                    we_i,
    output ddr_dma_pkg::word_t      data_o,
    // Scratchpad bus port
    output ddr_dma_pkg::spad_addr_t spad_addr_o,
    output logic                    spad_we_o,
    output ddr_dma_pkg::word_t      spad_wdata_o,
    input  ddr_dma_pkg::word_t      spad_rdata_i,
    // DMA setup
    output logic                    start_wr_o,
    output logic                    start_rd_o,
    output ddr_dma_pkg::dram_addr_t dram_addr_o,
    output ddr_dma_pkg::spad_addr_t dma_spad_addr_o,
    output ddr_dma_pkg::burst_len_t burst_len_o,
    input  logic                    idle_i
);

    logic                    spad_sel;
    logic                    ctrl_wr;
    logic                    spad_sel_q;
    ddr_dma_pkg::word_t      reg_rdata_q;
    ddr_dma_pkg::dram_addr_t dram_addr_q;
    ddr_dma_pkg::spad_addr_t spad_addr_q;
    ddr_dma_pkg::burst_len_t burst_len_q;

    assign spad_sel = (addr_i[15:12] == ddr_dma_pkg::SPAD_REGION);
    assign ctrl_wr  = we_i && (addr_i == ddr_dma_pkg::REG_CTRL);

    assign spad_addr_o  = addr_i[9:0];   // Bits 11:10 ignored
    assign spad_we_o    = we_i && spad_sel;
    assign spad_wdata_o = data_i;

    // Bit 0 picks the direction
    assign start_wr_o = ctrl_wr && data_i[0];
    assign start_rd_o = ctrl_wr && !data_i[0];

    assign dram_addr_o     = dram_addr_q;
    assign dma_spad_addr_o = spad_addr_q;
    assign burst_len_o     = burst_len_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            dram_addr_q <= '0;
            spad_addr_q <= '0;
            burst_len_q <= '0;
        end else if (we_i) begin
            case (addr_i)
                ddr_dma_pkg::REG_DRAM_ADDR: dram_addr_q <= data_i[26:2];
                ddr_dma_pkg::REG_SPAD_ADDR: spad_addr_q <= data_i[9:0];
                ddr_dma_pkg::REG_BURST_LEN: burst_len_q <= data_i[5:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spad_sel_q  <= 1'b0;
            reg_rdata_q <= '0;
        end else begin
            spad_sel_q <= spad_sel;
            case (addr_i)
                ddr_dma_pkg::REG_DRAM_ADDR: reg_rdata_q <= {5'b0, dram_addr_q, 2'b00};
                ddr_dma_pkg::REG_SPAD_ADDR: reg_rdata_q <= {22'b0, spad_addr_q};
                ddr_dma_pkg::REG_BURST_LEN: reg_rdata_q <= {26'b0, burst_len_q};
                ddr_dma_pkg::REG_CTRL:      reg_rdata_q <= {31'b0, idle_i};
                default:                    reg_rdata_q <= '0;
            endcase
        end
    end

    // RAM output is already registered
    assign data_o = spad_sel_q ? spad_rdata_i : reg_rdata_q;

endmodule

// ==== src/mig_port_model.sv ====
`timescale 1ns/100ps

module mig_port_model #(
    parameter int MEM_WORDS  = 4096,
    parameter int RD_LATENCY = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_en_i,
    input  ddr_dma_pkg::mig_instr_t cmd_instr_i,
    input  ddr_dma_pkg::burst_len_t cmd_bl_i,
    input  logic [29:0]             cmd_byte_addr_i,
    output logic                    cmd_full_o,
    input  logic                    wr_en_i,
    input  ddr_dma_pkg::word_t      wr_data_i,
    output logic                    wr_full_o,
    input  logic                    rd_en_i,
    output ddr_dma_pkg::word_t      rd_data_o,
    output logic                    rd_empty_o
);

    localparam int FIFO_DEPTH = 64;
    localparam int AW         = $clog2(MEM_WORDS);
    localparam int LAT_W      = $clog2(RD_LATENCY + 1);

    ddr_dma_pkg::word_t mem   [MEM_WORDS];
    ddr_dma_pkg::word_t wfifo [FIFO_DEPTH];
    ddr_dma_pkg::word_t rfifo [FIFO_DEPTH];

    logic [6:0]              w_wptr_q;
    logic [6:0]              w_rptr_q;
    logic [6:0]              r_wptr_q;
    logic [6:0]              r_rptr_q;
    logic                    busy_q;
    logic                    is_rd_q;
    ddr_dma_pkg::burst_len_t left_q;
    logic [LAT_W-1:0]        lat_q;
    logic [AW-1:0]           addr_q;
    logic                    w_empty;
    logic                    r_full;
    logic                    accept;
    logic                    w_push;
    logic                    w_pop;
    logic                    r_push;
    logic                    r_pop;

    // Extra pointer bit tells full from empty
    assign w_empty   = (w_wptr_q == w_rptr_q);
    assign wr_full_o = (w_wptr_q[6] != w_rptr_q[6]) && (w_wptr_q[5:0] == w_rptr_q[5:0]);
    assign r_full    = (r_wptr_q[6] != r_rptr_q[6]) && (r_wptr_q[5:0] == r_rptr_q[5:0]);
    assign rd_empty_o = (r_wptr_q == r_rptr_q);
    assign rd_data_o  = rfifo[r_rptr_q[5:0]];

    assign cmd_full_o = busy_q;
    assign accept     = cmd_en_i && !busy_q;
    assign w_push     = wr_en_i && !wr_full_o;
    assign r_pop      = rd_en_i && !rd_empty_o;
    assign w_pop      = busy_q && !is_rd_q && !w_empty;
    assign r_push     = busy_q && is_rd_q && (lat_q == '0) && !r_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_wptr_q <= '0;
            w_rptr_q <= '0;
            r_wptr_q <= '0;
            r_rptr_q <= '0;
            busy_q   <= 1'b0;
            is_rd_q  <= 1'b0;
            left_q   <= '0;
            lat_q    <= '0;
        end else begin
            if (w_push) w_wptr_q <= w_wptr_q + 1'b1;
            if (w_pop)  w_rptr_q <= w_rptr_q + 1'b1;
            if (r_push) r_wptr_q <= r_wptr_q + 1'b1;
            if (r_pop)  r_rptr_q <= r_rptr_q + 1'b1;
            if (accept) begin
                busy_q  <= 1'b1;
                is_rd_q <= (cmd_instr_i == ddr_dma_pkg::CMD_RD);
                left_q  <= cmd_bl_i;
                lat_q   <= LAT_W'(RD_LATENCY - 2);   // First word visible RD_LATENCY later
            end else if (busy_q) begin
                if (lat_q != '0) begin
                    lat_q <= lat_q - 1'b1;
                end
                if (w_pop || r_push) begin
                    if (left_q == '0) begin
                        busy_q <= 1'b0;
                    end else begin
                        left_q <= left_q - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= cmd_byte_addr_i[AW+1:2];   // Wraps modulo MEM_WORDS
        end else if (w_pop || r_push) begin
            addr_q <= addr_q + 1'b1;
        end
        if (w_push) wfifo[w_wptr_q[5:0]] <= wr_data_i;
        if (w_pop)  mem[addr_q] <= wfifo[w_rptr_q[5:0]];
        if (r_push) rfifo[r_wptr_q[5:0]] <= mem[addr_q];
    end

endmodule

// ==== src/spad_ram.sv ====
`timescale 1ns/100ps

module spad_ram (
    input  logic                    clk,
    // Bus port
    input  ddr_dma_pkg::spad_addr_t a_addr_i,
    input  logic                    a_we_i,
    input  ddr_dma_pkg::word_t      a_wdata_i,
    output ddr_dma_pkg::word_t      a_rdata_o,
    // DMA port
    input  ddr_dma_pkg::spad_addr_t b_addr_i,
    input  logic                    b_we_i,
    input  ddr_dma_pkg::word_t      b_wdata_i,
    output ddr_dma_pkg::word_t      b_rdata_o
);

    localparam int DEPTH = 1024;

    ddr_dma_pkg::word_t mem [DEPTH];

    // Read-first on both ports
    always_ff @(posedge clk) begin
        a_rdata_o <= mem[a_addr_i];
        b_rdata_o <= mem[b_addr_i];
    end

    // Port B written last so the DMA wins a same-word collision
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
        end
    end

endmodule
